/* source/cw_pkg.sv */
`default_nettype none

package cw_pkg;

    // link and bus widths.
    localparam int RW           = 16;
    localparam int WB_ADDR_W    = 24;
    localparam int SEL_W        = RW / 8;
    localparam int MAX_BRST_LOG = 3;
    localparam int BRST_W       = 3;
    localparam int SRAM_AW      = 8;

    // burst codes, bit 0 selects eight words.
    localparam logic [BRST_W-1:0] BRST_1 = 3'd0;
    localparam logic [BRST_W-1:0] BRST_4 = 3'd2;
    localparam logic [BRST_W-1:0] BRST_8 = 3'd1;

    // decompressor states.
    localparam int SW = 4;
    localparam logic [SW-1:0] S_IDLE       = 4'd0;
    localparam logic [SW-1:0] S_HDR_1      = 4'd1;
    localparam logic [SW-1:0] S_DATA_R     = 4'd2;
    localparam logic [SW-1:0] S_DATA_W     = 4'd3;
    localparam logic [SW-1:0] S_DATA_W_PRE = 4'd4;

    // link master states.
    localparam int MW = 3;
    localparam logic [MW-1:0] M_IDLE = 3'd0;
    localparam logic [MW-1:0] M_HDR  = 3'd1;
    localparam logic [MW-1:0] M_ADR  = 3'd2;
    localparam logic [MW-1:0] M_WR   = 3'd3;
    localparam logic [MW-1:0] M_RD   = 3'd4;

    // one link word, seen as a header or as raw data.
    typedef union packed {
        struct packed {
            logic [WB_ADDR_W-RW-1:0] adr_hi;
            logic [BRST_W-1:0]       burst;
            logic                    we;
            logic                    rsvd;
            logic [SEL_W-1:0]        sel;
            logic                    start;
        } hdr;
        logic [RW-1:0] data;
    } cw_word_t;

    // index of the last word of a burst.
    function automatic logic [MAX_BRST_LOG-1:0] brst_end(input logic [BRST_W-1:0] code);
        logic [MAX_BRST_LOG-1:0] last;
        if (code == BRST_1) begin
            last = '0;
        end else if (|(code & BRST_8)) begin
            last = 3'd7;
        end else begin
            last = 3'd3;
        end
        return last;
    endfunction

endpackage

`default_nettype wire

/* source/cw_link_master.sv */
`default_nettype none

module cw_link_master
    import cw_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire                  i_req_valid,
    input  wire                  i_req_we,
    input  wire [WB_ADDR_W-1:0]  i_req_adr,
    input  wire [SEL_W-1:0]      i_req_sel,
    input  wire [BRST_W-1:0]     i_req_burst,
    input  wire [RW-1:0]         i_wdata,

    output logic                 o_wdata_take,
    output logic [RW-1:0]        o_rdata,
    output logic                 o_rdata_valid,
    output logic                 o_rdata_err,
    output logic                 o_busy,
    output logic                 o_done,

    output logic [RW-1:0]        o_cw_dat,
    output logic                 o_cw_req,
    output logic                 o_cw_dir,
    input  wire [RW-1:0]         i_cw_dat,
    input  wire                  i_cw_ack,
    input  wire                  i_cw_err
);

    logic [MW-1:0]           state;
    logic [RW-1:0]           adr_lo;
    logic                    req_we;
    logic [MAX_BRST_LOG-1:0] cnt;
    logic [MAX_BRST_LOG-1:0] cnt_end;
    logic                    answer;
    cw_word_t                hdr_w;

    assign answer = i_cw_ack | i_cw_err;

    // header word built from the host request.
    always_comb begin
        hdr_w = '0;
        hdr_w.hdr.adr_hi = i_req_adr[WB_ADDR_W-1:RW];
        hdr_w.hdr.burst  = i_req_burst;
        hdr_w.hdr.we     = i_req_we;
        hdr_w.hdr.rsvd   = 1'b0;
        hdr_w.hdr.sel    = i_req_sel;
        hdr_w.hdr.start  = 1'b1;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= M_IDLE;
            o_cw_req      <= 1'b0;
            o_cw_dir      <= 1'b1;
            o_busy        <= 1'b0;
            o_done        <= 1'b0;
            o_rdata_valid <= 1'b0;
            o_wdata_take  <= 1'b0;
            cnt           <= '0;
        end else begin
            o_cw_req      <= 1'b0;
            o_done        <= 1'b0;
            o_rdata_valid <= 1'b0;
            o_wdata_take  <= 1'b0;

            // every answered word goes back to the host.
            if ((state == M_WR || state == M_RD) && answer) begin
                o_rdata_valid <= 1'b1;
                o_rdata       <= i_cw_dat;
                o_rdata_err   <= i_cw_err;
            end

            case (state)
                M_HDR: begin
                    o_cw_dat <= adr_lo;
                    state    <= M_ADR;
                end
                M_ADR: begin
                    if (i_cw_ack) begin
                        if (req_we) begin
                            o_cw_dat     <= i_wdata;
                            o_wdata_take <= 1'b1;
                            state        <= M_WR;
                        end else begin
                            o_cw_dir <= 1'b0;
                            state    <= M_RD;
                        end
                    end
                end
                M_WR, M_RD: begin
                    if (answer) begin
                        if (cnt == cnt_end) begin
                            o_done   <= 1'b1;
                            o_busy   <= 1'b0;
                            o_cw_dir <= 1'b1;
                            state    <= M_IDLE;
                        end else begin
                            cnt <= cnt + 1'b1;
                            if (state == M_WR) begin
                                // next write word once the last one was answered.
                                o_cw_dat     <= i_wdata;
                                o_cw_req     <= 1'b1;
                                o_wdata_take <= 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    o_cw_dir <= 1'b1;
                    if (i_req_valid) begin
                        o_cw_dat <= hdr_w.data;
                        o_cw_req <= 1'b1;
                        o_busy   <= 1'b1;
                        adr_lo   <= i_req_adr[RW-1:0];
                        req_we   <= i_req_we;
                        cnt_end  <= brst_end(i_req_burst);
                        cnt      <= '0;
                        state    <= M_HDR;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/cw_wb_decomp.sv */
`default_nettype none

module cw_wb_decomp
    import cw_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire [RW-1:0]         i_cw_dat,
    input  wire                  i_cw_req,
    input  wire                  i_cw_dir,
    output logic [RW-1:0]        o_cw_dat,
    output logic                 o_cw_ack,
    output logic                 o_cw_err,

    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic [WB_ADDR_W-1:0] o_wb_adr,
    output logic [RW-1:0]        o_wb_dat,
    output logic                 o_wb_we,
    output logic [SEL_W-1:0]     o_wb_sel,
    input  wire [RW-1:0]         i_wb_dat,
    input  wire                  i_wb_ack,
    input  wire                  i_wb_err
);

    logic [SW-1:0]           state;
    logic [WB_ADDR_W-1:0]    base_adr;
    logic [MAX_BRST_LOG-1:0] burst_cnt;
    logic [MAX_BRST_LOG-1:0] burst_end;
    logic                    wb_answer;
    logic                    last_word;
    cw_word_t                cw_in;

    assign cw_in     = i_cw_dat;
    assign wb_answer = i_wb_ack | i_wb_err;
    assign last_word = (burst_cnt == burst_end);

    // word address walks the burst from the base.
    assign o_wb_adr = base_adr + {{(WB_ADDR_W-MAX_BRST_LOG){1'b0}}, burst_cnt};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= S_IDLE;
            o_cw_ack  <= 1'b0;
            o_cw_err  <= 1'b0;
            o_wb_cyc  <= 1'b0;
            o_wb_stb  <= 1'b0;
            burst_cnt <= '0;
        end else begin
            o_cw_ack <= 1'b0;
            o_cw_err <= 1'b0;

            case (state)
                // ########################################
                // header and address words.
                // ########################################
                S_HDR_1: begin
                    base_adr[RW-1:0] <= cw_in.data;
                    if (o_wb_we) begin
                        state <= S_DATA_W_PRE;
                    end else begin
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        state    <= S_DATA_R;
                    end
                end

                // ########################################
                // reads keep stb up for the whole burst.
                // ########################################
                S_DATA_R: begin
                    if (wb_answer) begin
                        o_cw_ack <= i_wb_ack;
                        o_cw_err <= i_wb_err;
                        o_cw_dat <= i_wb_dat;
                        if (last_word) begin
                            o_wb_cyc <= 1'b0;
                            o_wb_stb <= 1'b0;
                            state    <= S_IDLE;
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                        end
                    end
                end

                // ########################################
                // writes drop stb between words.
                // ########################################
                S_DATA_W_PRE: begin
                    o_wb_cyc <= 1'b1;
                    o_wb_stb <= 1'b1;
                    o_wb_dat <= cw_in.data;
                    state    <= S_DATA_W;
                end
                S_DATA_W: begin
                    if (wb_answer) begin
                        o_cw_ack <= i_wb_ack;
                        o_cw_err <= i_wb_err;
                        o_wb_stb <= 1'b0;
                        if (last_word) begin
                            o_wb_cyc <= 1'b0;
                            state    <= S_IDLE;
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                        end
                    end else if (!o_wb_stb && i_cw_req) begin
                        // next word from the link.
                        o_wb_stb <= 1'b1;
                        o_wb_dat <= cw_in.data;
                    end
                end

                default: begin
                    o_wb_cyc <= 1'b0;
                    o_wb_stb <= 1'b0;
                    if (i_cw_req && i_cw_dir && cw_in.hdr.start) begin
                        base_adr[WB_ADDR_W-1:RW] <= cw_in.hdr.adr_hi;
                        o_wb_we   <= cw_in.hdr.we;
                        o_wb_sel  <= cw_in.hdr.sel;
                        burst_end <= brst_end(cw_in.hdr.burst);
                        burst_cnt <= '0;
                        o_cw_ack  <= 1'b1;
                        state     <= S_HDR_1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/wb_sram.sv */
`default_nettype none

module wb_sram
    import cw_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire                  i_wb_cyc,
    input  wire                  i_wb_stb,
    input  wire [WB_ADDR_W-1:0]  i_wb_adr,
    input  wire [RW-1:0]         i_wb_dat,
    input  wire                  i_wb_we,
    input  wire [SEL_W-1:0]      i_wb_sel,
    output logic [RW-1:0]        o_wb_dat,
    output logic                 o_wb_ack,
    output logic                 o_wb_err
);

    logic [RW-1:0] mem [0:(1<<SRAM_AW)-1];
    logic          mapped;
    logic          take;

    assign mapped = ~|i_wb_adr[WB_ADDR_W-1:SRAM_AW];

    // one wait state, no new strobe while an answer is out.
    assign take = i_wb_cyc & i_wb_stb & ~(o_wb_ack | o_wb_err);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            o_wb_ack <= take & mapped;
            o_wb_err <= take & ~mapped;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take && mapped) begin
            if (i_wb_we) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (i_wb_sel[i]) begin
                        mem[i_wb_adr[SRAM_AW-1:0]][i*8 +: 8] <= i_wb_dat[i*8 +: 8];
                    end
                end
            end else begin
                o_wb_dat <= mem[i_wb_adr[SRAM_AW-1:0]];
            end
        end
    end

endmodule

`default_nettype wire

/* source/cw_wb_bridge_top.sv */
`default_nettype none

module cw_wb_bridge_top
    import cw_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire                  i_req_valid,
    input  wire                  i_req_we,
    input  wire [WB_ADDR_W-1:0]  i_req_adr,
    input  wire [SEL_W-1:0]      i_req_sel,
    input  wire [BRST_W-1:0]     i_req_burst,
    input  wire [RW-1:0]         i_wdata,

    output logic                 o_wdata_take,
    output logic [RW-1:0]        o_rdata,
    output logic                 o_rdata_valid,
    output logic                 o_rdata_err,
    output logic                 o_busy,
    output logic                 o_done
);

    // cw link.
    logic [RW-1:0]        cw_dat;
    logic [RW-1:0]        m_cw_dat;
    logic [RW-1:0]        d_cw_dat;
    logic                 cw_req;
    logic                 cw_dir;
    logic                 cw_ack;
    logic                 cw_err;

    // wishbone.
    logic                 wb_cyc;
    logic                 wb_stb;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [RW-1:0]        wb_dat_w;
    logic [RW-1:0]        wb_dat_r;
    logic                 wb_we;
    logic [SEL_W-1:0]     wb_sel;
    logic                 wb_ack;
    logic                 wb_err;

    // shared link word, the master owns it while cw_dir is high.
    assign cw_dat = cw_dir ? m_cw_dat : d_cw_dat;

    cw_link_master master0 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_valid   (i_req_valid),
        .i_req_we      (i_req_we),
        .i_req_adr     (i_req_adr),
        .i_req_sel     (i_req_sel),
        .i_req_burst   (i_req_burst),
        .i_wdata       (i_wdata),
        .o_wdata_take  (o_wdata_take),
        .o_rdata       (o_rdata),
        .o_rdata_valid (o_rdata_valid),
        .o_rdata_err   (o_rdata_err),
        .o_busy        (o_busy),
        .o_done        (o_done),
        .o_cw_dat      (m_cw_dat),
        .o_cw_req      (cw_req),
        .o_cw_dir      (cw_dir),
        .i_cw_dat      (cw_dat),
        .i_cw_ack      (cw_ack),
        .i_cw_err      (cw_err)
    );

    cw_wb_decomp decomp0 (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_cw_dat (cw_dat),
        .i_cw_req (cw_req),
        .i_cw_dir (cw_dir),
        .o_cw_dat (d_cw_dat),
        .o_cw_ack (cw_ack),
        .o_cw_err (cw_err),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_adr (wb_adr),
        .o_wb_dat (wb_dat_w),
        .o_wb_we  (wb_we),
        .o_wb_sel (wb_sel),
        .i_wb_dat (wb_dat_r),
        .i_wb_ack (wb_ack),
        .i_wb_err (wb_err)
    );

    wb_sram sram0 (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .i_wb_we  (wb_we),
        .i_wb_sel (wb_sel),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack),
        .o_wb_err (wb_err)
    );

endmodule

`default_nettype wire

/* sim/cw_wb_bridge_properties.sv */
`default_nettype none

module decomp_protocol_checks
    import cw_pkg::*;
(
    input wire                 i_clk,
    input wire                 i_rst,
    input wire [SW-1:0]        i_state,
    input wire [RW-1:0]        i_cw_dat,
    input wire                 i_cw_req,
    input wire                 i_cw_dir,
    input wire [WB_ADDR_W-1:0] i_wb_adr,
    input wire                 i_wb_cyc,
    input wire                 i_wb_stb,
    input wire                 i_cw_ack,
    input wire                 i_cw_err
);

    cw_word_t             link_w;
    logic [WB_ADDR_W-1:0] link_base;
    logic [WB_ADDR_W-1:0] adr_off;

    assign link_w  = i_cw_dat;
    assign adr_off = i_wb_adr - link_base;

    // base address as sent over the link.
    always_ff @(posedge i_clk) begin
        if (i_state == S_IDLE && i_cw_req && i_cw_dir && link_w.hdr.start) begin
            link_base[WB_ADDR_W-1:RW] <= link_w.hdr.adr_hi;
        end
        if (i_state == S_HDR_1) begin
            link_base[RW-1:0] <= link_w.data;
        end
    end

    stb_needs_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_stb |-> i_wb_cyc)
        else $error("wb_stb high without wb_cyc");

    ack_err_apart: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_cw_ack && i_cw_err))
        else $error("cw_ack and cw_err high together");

    // low address word arrives in S_HDR_1.
    adr_in_burst: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_state != S_IDLE && i_state != S_HDR_1) |-> (adr_off <= 24'd7))
        else $error("wb address outside base plus 7");

    bus_quiet_after_reset: assert property (@(posedge i_clk)
        i_rst |=> (!i_wb_cyc && !i_wb_stb))
        else $error("wb_cyc or wb_stb high after reset");

endmodule

bind cw_wb_decomp decomp_protocol_checks checks0 (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_state  (state),
    .i_cw_dat (i_cw_dat),
    .i_cw_req (i_cw_req),
    .i_cw_dir (i_cw_dir),
    .i_wb_adr (o_wb_adr),
    .i_wb_cyc (o_wb_cyc),
    .i_wb_stb (o_wb_stb),
    .i_cw_ack (o_cw_ack),
    .i_cw_err (o_cw_err)
);

`default_nettype wire

/* sim/cw_wb_bridge_tb.sv */
`default_nettype none

module cw_wb_bridge_tb
    import cw_pkg::*;
;

    localparam int N_FILL     = (1 << SRAM_AW) / 8;
    localparam int N_DIRECTED = 12;
    localparam int N_RAND     = 40;
    localparam int N_REQ      = N_FILL + N_DIRECTED + N_RAND;
    localparam int CYCLE_LIMIT = N_REQ * 40;
    localparam int DONE_WAIT  = 40;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_req_valid;
    logic                 i_req_we;
    logic [WB_ADDR_W-1:0] i_req_adr;
    logic [SEL_W-1:0]     i_req_sel;
    logic [BRST_W-1:0]    i_req_burst;
    logic [RW-1:0]        i_wdata;
    logic                 o_wdata_take;
    logic [RW-1:0]        o_rdata;
    logic                 o_rdata_valid;
    logic                 o_rdata_err;
    logic                 o_busy;
    logic                 o_done;

    logic [RW-1:0] model_mem [0:(1<<SRAM_AW)-1];
    logic [RW-1:0] wr_words [0:7];
    logic [RW-1:0] exp_word [$];
    bit            exp_err [$];
    bit            exp_chk [$];

    integer seed      = 32'hbe2a_b84c;
    int     errors    = 0;
    int     rx_total  = 0;
    int     req_count = 0;
    int     cycles    = 0;

    cw_wb_bridge_top dut0 (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_req_valid   (i_req_valid),
        .i_req_we      (i_req_we),
        .i_req_adr     (i_req_adr),
        .i_req_sel     (i_req_sel),
        .i_req_burst   (i_req_burst),
        .i_wdata       (i_wdata),
        .o_wdata_take  (o_wdata_take),
        .o_rdata       (o_rdata),
        .o_rdata_valid (o_rdata_valid),
        .o_rdata_err   (o_rdata_err),
        .o_busy        (o_busy),
        .o_done        (o_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // watchdog.
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d errors", cycles, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [RW-1:0] exp,
                             input logic [RW-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end
    endtask

    // ########################################
    // reference model
    // ########################################

    function automatic int burst_len(input logic [BRST_W-1:0] code);
        if (code == BRST_1) begin
            return 1;
        end else if (code[0]) begin
            return 8;
        end
        return 4;
    endfunction

    // returns {err, word}.
    function automatic logic [RW:0] ref_read(input logic [WB_ADDR_W-1:0] adr);
        if (adr[WB_ADDR_W-1:SRAM_AW] != '0) begin
            return {1'b1, {RW{1'b0}}};
        end
        return {1'b0, model_mem[adr[SRAM_AW-1:0]]};
    endfunction

    task automatic model_write(input logic [WB_ADDR_W-1:0] adr, input logic [SEL_W-1:0] sel,
                               input logic [RW-1:0] data);
        if (adr[WB_ADDR_W-1:SRAM_AW] == '0) begin
            if (sel[0]) begin
                model_mem[adr[SRAM_AW-1:0]][7:0] = data[7:0];
            end
            if (sel[1]) begin
                model_mem[adr[SRAM_AW-1:0]][15:8] = data[15:8];
            end
        end
    endtask

    function automatic logic [RW-1:0] fill_word(input logic [SRAM_AW-1:0] adr);
        return {adr ^ 8'h3c, ~adr};
    endfunction

    task automatic randomize_words();
        int k;
        logic [31:0] r;
        for (k = 0; k < 8; k++) begin
            r = $random(seed);
            wr_words[k[2:0]] = r[RW-1:0];
        end
    endtask

    // ########################################
    // one host request
    // ########################################

    task automatic run_request(input logic we, input logic [WB_ADDR_W-1:0] adr,
                               input logic [SEL_W-1:0] sel, input logic [BRST_W-1:0] burst);
        int len;
        int k;
        int idx;
        int waited;
        int rx_start;
        bit done_seen;
        logic [WB_ADDR_W-1:0] a;
        logic [RW:0] r;
        len = burst_len(burst);
        req_count++;
        for (k = 0; k < len; k++) begin
            a = adr + WB_ADDR_W'(k);
            if (we) begin
                model_write(a, sel, wr_words[k[2:0]]);
                exp_word.push_back('0);
                exp_err.push_back(a[WB_ADDR_W-1:SRAM_AW] != '0);
                exp_chk.push_back(1'b0);
            end else begin
                r = ref_read(a);
                exp_word.push_back(r[RW-1:0]);
                exp_err.push_back(r[RW]);
                exp_chk.push_back(!r[RW]);
            end
        end
        rx_start = rx_total;
        check_val("o_busy", '0, RW'(o_busy));
        i_req_valid = 1'b1;
        i_req_we    = we;
        i_req_adr   = adr;
        i_req_sel   = sel;
        i_req_burst = burst;
        i_wdata     = wr_words[0];
        idx         = 0;
        @(posedge i_clk);
        #10;
        i_req_valid = 1'b0;
        check_val("o_busy", RW'(1), RW'(o_busy));
        waited    = 0;
        done_seen = 1'b0;
        while (!done_seen && waited < DONE_WAIT) begin
            // next write word once the current one was taken.
            if (o_wdata_take === 1'b1) begin
                idx++;
                if (idx < 8) begin
                    i_wdata = wr_words[idx[2:0]];
                end
            end
            done_seen = (o_done === 1'b1);
            if (!done_seen) begin
                @(posedge i_clk);
                #10;
                waited++;
            end
        end
        if (!done_seen) begin
            errors++;
            $display("request to address %h never pulsed o_done", adr);
        end
        @(posedge i_clk);
        #10;
        check_val("o_rdata_valid count", RW'(len), RW'(rx_total - rx_start));
        check_val("o_wdata_take count", we ? RW'(len) : '0, RW'(idx));
        exp_word.delete();
        exp_err.delete();
        exp_chk.delete();
    endtask

    // compares each returned word in order.
    always @(negedge i_clk) begin : compare_words
        logic [RW-1:0] e_word;
        bit e_err;
        bit e_chk;
        if (o_rdata_valid === 1'b1) begin
            rx_total++;
            if (exp_word.size() == 0) begin
                errors++;
                $display("o_rdata_valid pulsed with no word outstanding");
            end else begin
                e_word = exp_word.pop_front();
                e_err  = exp_err.pop_front();
                e_chk  = exp_chk.pop_front();
                check_val("o_rdata_err", RW'(e_err), RW'(o_rdata_err));
                if (e_chk) begin
                    check_val("o_rdata", e_word, o_rdata);
                end
            end
        end
    end

    initial begin : stimulus
        int base;
        int k;
        int n;
        logic [31:0] r;
        logic [WB_ADDR_W-1:0] rnd_adr;
        logic [BRST_W-1:0] rnd_burst;
        i_rst       = 1'b1;
        i_req_valid = 1'b0;
        i_req_we    = 1'b0;
        i_req_adr   = '0;
        i_req_sel   = '0;
        i_req_burst = '0;
        i_wdata     = '0;
        repeat (2) @(posedge i_clk);
        #10;
        i_rst = 1'b0;
        check_val("o_busy", '0, RW'(o_busy));
        check_val("o_done", '0, RW'(o_done));
        check_val("o_rdata_valid", '0, RW'(o_rdata_valid));
        check_val("o_wdata_take", '0, RW'(o_wdata_take));

        // whole memory gets a known pattern first.
        for (base = 0; base < (1 << SRAM_AW); base += 8) begin
            for (k = 0; k < 8; k++) begin
                wr_words[k[2:0]] = fill_word(SRAM_AW'(base + k));
            end
            run_request(1'b1, WB_ADDR_W'(base), 2'b11, BRST_8);
        end

        wr_words[0] = 16'hc0de;
        run_request(1'b1, 24'h000010, 2'b11, BRST_1);
        run_request(1'b0, 24'h000010, 2'b11, BRST_1);

        randomize_words();
        run_request(1'b1, 24'h000040, 2'b11, BRST_4);
        run_request(1'b0, 24'h000040, 2'b11, BRST_4);
        randomize_words();
        run_request(1'b1, 24'h000080, 2'b11, BRST_8);
        run_request(1'b0, 24'h000080, 2'b11, BRST_8);

        // byte lanes.
        wr_words[0] = 16'h5aa5;
        run_request(1'b1, 24'h000020, 2'b01, BRST_1);
        wr_words[0] = 16'h9669;
        run_request(1'b1, 24'h000020, 2'b10, BRST_1);
        run_request(1'b0, 24'h000020, 2'b11, BRST_1);

        // unmapped page, then its alias.
        randomize_words();
        run_request(1'b1, 24'h010045, 2'b11, BRST_4);
        run_request(1'b0, 24'h010045, 2'b11, BRST_4);
        run_request(1'b0, 24'h000045, 2'b11, BRST_4);

        for (n = 0; n < N_RAND; n++) begin
            r = $random(seed);
            rnd_adr = {15'd0, &r[14:12], r[11:4]};
            if (r[18:17] == 2'd0) begin
                rnd_burst = BRST_1;
            end else if (r[18:17] == 2'd1) begin
                rnd_burst = BRST_4;
            end else begin
                rnd_burst = BRST_8;
            end
            randomize_words();
            run_request(r[0], rnd_adr, r[16:15], rnd_burst);
        end

        repeat (2) @(posedge i_clk);
        $display("run finished with %0d errors over %0d requests", errors, req_count);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cw_wb_bridge_top.f */
source/cw_pkg.sv
source/cw_link_master.sv
source/cw_wb_decomp.sv
source/wb_sram.sv
source/cw_wb_bridge_top.sv
sim/cw_wb_bridge_properties.sv
sim/cw_wb_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cw bridge testbench with verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module cw_wb_bridge_tb \
    -Mdir obj_dir \
    -f cw_wb_bridge_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcw_wb_bridge_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

exit 0
